//--- files.f
+incdir+source
source/stb_pkg.sv
source/stb_create_decode.sv
source/stb_entry_fsm.sv
source/stb_entry_data.sv
source/stb_entry_result.sv
source/stb_entry.sv
tb/stb_entry_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the store buffer entry testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module stb_entry_tb \
  -f files.f -o stb_entry_sim || { echo "Build failed"; exit 1; }

./obj_dir/stb_entry_sim > sim.log 2>&1 ; cat sim.log

grep -q "Done: errors found" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "Simulation did not finish"; exit 1; }
echo "Simulation passed"

//--- source/stb_create_decode.sv
// ========================================
// Create decode. Picks the route of a new
// store and builds its bus attributes.
// Purely combinational, feeds the FSM
// ========================================
`include "stb_params.svh"

module stb_create_decode
  import stb_pkg::*;
(
  input  stb_create_t create,
  input  logic        dcache_wb,
  output stb_state_e  route,
  output stb_attr_t   attr
);

  logic ca;
  logic so;
  logic buf_bit;
  logic wo;

  // ========================================
  // Attribute bits of the store
  // ========================================
  assign ca = create.attr[`STB_ATTR_CA];
  assign so = create.attr[`STB_ATTR_SO];

  // Write-ordered unless strongly ordered
  assign wo = ~so;

  // Cacheable stores follow the write-back mode
  assign buf_bit = ca ? dcache_wb : create.attr[`STB_ATTR_BUF];

  // ========================================
  // Route selection
  // ========================================
  always_comb begin
    if (create.cache_hit) begin
      route = WCA;
    end else if (ca && !create.lock) begin
      route = MERGE;
    end else begin
      route = WBUS;
    end
  end

  // ========================================
  // Bus attributes
  // ========================================
  always_comb begin
    attr.wo = wo;

    // Write-ordered stores go out as a full doubleword
    if (wo) begin
      attr.size = 3'b011;
    end else begin
      attr.size = {1'b0, create.size};
    end

    // Data access, privileged bit from the mode
    attr.prot  = {1'b0, 1'b1, create.priv_mode[0]};
    attr.user  = create.priv_mode[1];

    attr.cache = {create.alct, ca, wo, buf_bit};
  end

endmodule

//--- source/stb_entry.sv
// ========================================
// One store buffer entry. Connects create
// decode, the entry FSM, the data path and
// the hit and request logic
// ========================================
`include "stb_params.svh"

module stb_entry
  import stb_pkg::*;
(
  input  logic                  stb_fsm_clk,
  input  logic                  cpurst_b,
  input  logic                  create_en,
  input  stb_create_t           create,
  input  logic                  dcache_wb,
  input  logic                  merge_req,
  input  logic [`STB_DATAW-1:0] merge_data,
  input  logic [`STB_BYTEW-1:0] merge_bytes_vld,
  input  logic                  merge_finish,
  input  stb_pa_u               dc_pa,
  input  logic [`STB_BYTEW-1:0] dc_bytes_vld,
  input  logic                  fwd_vld,
  input  logic [4:0]            fwd_dest_reg,
  input  logic [`STB_DATAW-1:0] fwd_data,
  input  logic                  wca_grant,
  input  logic                  wbus_cmplt,
  output logic                  entry_vld,
  output logic                  so_vld,
  output logic                  dcache_req,
  output logic                  biu_req,
  output logic                  merge_en,
  output logic                  pop_vld,
  output logic                  fwd_hit,
  output logic                  hit_addr,
  output logic                  hit_addr_wca,
  output logic                  hit_full,
  output logic                  hit_part,
  output logic                  hit_idx,
  output stb_req_t              req
);

  stb_state_e            route;
  stb_state_e            state;
  stb_attr_t             attr_dec;
  stb_attr_t             attr;
  logic                  bytes_full;
  logic [`STB_DATAW-1:0] data;
  logic [`STB_BYTEW-1:0] bytes_vld;
  stb_pa_u               pa_q;
  logic [1:0]            virt_idx_q;
  logic [3:0]            way_q;

  // Address, index and way captured at create
  always_ff @(posedge stb_fsm_clk) begin
    if (create_en) begin
      pa_q       <= create.pa;
      virt_idx_q <= create.virt_idx;
      way_q      <= create.way;
    end
  end

  stb_create_decode u_decode (
    .create    (create),
    .dcache_wb (dcache_wb),
    .route     (route),
    .attr      (attr_dec)
  );

  stb_entry_fsm u_fsm (
    .stb_fsm_clk  (stb_fsm_clk),
    .cpurst_b     (cpurst_b),
    .create_en    (create_en),
    .create       (create),
    .route        (route),
    .attr_in      (attr_dec),
    .dcache_wb    (dcache_wb),
    .fwd_hit      (fwd_hit),
    .bytes_full   (bytes_full),
    .merge_finish (merge_finish),
    .wca_grant    (wca_grant),
    .wbus_cmplt   (wbus_cmplt),
    .state        (state),
    .attr         (attr),
    .entry_vld    (entry_vld),
    .pop_vld      (pop_vld)
  );

  stb_entry_data u_data (
    .stb_fsm_clk     (stb_fsm_clk),
    .create_en       (create_en),
    .create          (create),
    .state           (state),
    .wo              (attr.wo),
    .hit_addr        (hit_addr),
    .merge_req       (merge_req),
    .merge_data      (merge_data),
    .merge_bytes_vld (merge_bytes_vld),
    .fwd_vld         (fwd_vld),
    .fwd_dest_reg    (fwd_dest_reg),
    .fwd_data        (fwd_data),
    .fwd_hit         (fwd_hit),
    .bytes_full      (bytes_full),
    .merge_en        (merge_en),
    .data            (data),
    .bytes_vld       (bytes_vld)
  );

  stb_entry_result u_result (
    .state        (state),
    .pa           (pa_q),
    .attr         (attr),
    .way          (way_q),
    .virt_idx     (virt_idx_q),
    .data         (data),
    .bytes_vld    (bytes_vld),
    .dc_pa        (dc_pa),
    .dc_bytes_vld (dc_bytes_vld),
    .hit_addr     (hit_addr),
    .hit_addr_wca (hit_addr_wca),
    .hit_full     (hit_full),
    .hit_part     (hit_part),
    .hit_idx      (hit_idx),
    .so_vld       (so_vld),
    .dcache_req   (dcache_req),
    .biu_req      (biu_req),
    .req          (req)
  );

endmodule

//--- source/stb_entry_data.sv
// ========================================
// Entry data path. Loads store data at
// create, takes forwarded source data and
// merges later stores to the same doubleword
// ========================================
`include "stb_params.svh"

module stb_entry_data
  import stb_pkg::*;
(
  input  logic                  stb_fsm_clk,
  input  logic                  create_en,
  input  stb_create_t           create,
  input  stb_state_e            state,
  input  logic                  wo,
  input  logic                  hit_addr,
  input  logic                  merge_req,
  input  logic [`STB_DATAW-1:0] merge_data,
  input  logic [`STB_BYTEW-1:0] merge_bytes_vld,
  input  logic                  fwd_vld,
  input  logic [4:0]            fwd_dest_reg,
  input  logic [`STB_DATAW-1:0] fwd_data,
  output logic                  fwd_hit,
  output logic                  bytes_full,
  output logic                  merge_en,
  output logic [`STB_DATAW-1:0] data,
  output logic [`STB_BYTEW-1:0] bytes_vld
);

  logic [4:0]              src2_reg_q;
  logic [2:0]              shift_q;
  logic [2*`STB_DATAW-1:0] fwd_dbl;
  logic [`STB_DATAW-1:0]   fwd_rot;
  logic [`STB_DATAW-1:0]   merge_mask;
  logic                    merge_vld;

  // ========================================
  // Forwarding
  // ========================================
  assign fwd_hit = (state == FWD) && fwd_vld && (fwd_dest_reg == src2_reg_q);

  // Rotate right by shift bytes to put the data in byte lanes
  assign fwd_dbl = {fwd_data, fwd_data} >> {shift_q, 3'b000};
  assign fwd_rot = fwd_dbl[`STB_DATAW-1:0];

  // ========================================
  // Merging
  // ========================================
  assign merge_en  = (state == MERGE) && wo && hit_addr;
  assign merge_vld = merge_req && merge_en;

  always_comb begin
    for (int i = 0; i < `STB_BYTEW; i++) begin
      merge_mask[i*8 +: 8] = {8{merge_bytes_vld[i]}};
    end
  end

  // Data registers, create wins over forward and merge
  always_ff @(posedge stb_fsm_clk) begin
    if (create_en) begin
      data       <= create.data;
      bytes_vld  <= create.bytes_vld;
      src2_reg_q <= create.src2_reg;
      shift_q    <= create.shift;
    end else if (fwd_hit) begin
      data       <= fwd_rot;
    end else if (merge_vld) begin
      data       <= (merge_mask & merge_data) | (~merge_mask & data);
      bytes_vld  <= bytes_vld | merge_bytes_vld;
    end
  end

  assign bytes_full = &bytes_vld;

endmodule

//--- source/stb_entry_fsm.sv
// ========================================
// Entry state machine. Tracks one store
// from create to pop and keeps its route,
// write-back mode and bus attributes
// ========================================
module stb_entry_fsm
  import stb_pkg::*;
(
  input  logic        stb_fsm_clk,
  input  logic        cpurst_b,
  input  logic        create_en,
  input  stb_create_t create,
  input  stb_state_e  route,
  input  stb_attr_t   attr_in,
  input  logic        dcache_wb,
  input  logic        fwd_hit,
  input  logic        bytes_full,
  input  logic        merge_finish,
  input  logic        wca_grant,
  input  logic        wbus_cmplt,
  output stb_state_e  state,
  output stb_attr_t   attr,
  output logic        entry_vld,
  output logic        pop_vld
);

  stb_state_e cur_state;
  stb_state_e next_state;
  stb_state_e route_q;
  logic       wb_q;

  // ========================================
  // State register
  // ========================================
  always_ff @(posedge stb_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      cur_state <= IDLE;
    end else begin
      cur_state <= next_state;
    end
  end

  always_comb begin
    next_state = cur_state;
    case (cur_state)
      IDLE: begin
        if (create_en) begin
          // Wait for source data before taking the route
          next_state = create.src2_depd ? FWD : route;
        end
      end
      FWD: begin
        if (fwd_hit) begin
          next_state = route_q;
        end
      end
      WCA: begin
        if (wca_grant) begin
          next_state = wb_q ? IDLE : WBUS;
        end
      end
      MERGE: begin
        if (merge_finish || bytes_full) begin
          next_state = WBUS;
        end
      end
      WBUS: begin
        if (wbus_cmplt) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  // ========================================
  // Per-store control captured at create
  // ========================================
  always_ff @(posedge stb_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      route_q <= IDLE;
      wb_q    <= 1'b0;
      attr    <= '0;
    end else if (create_en) begin
      route_q <= route;
      wb_q    <= dcache_wb;
      attr    <= attr_in;
    end
  end

  // Write-through stores still owe a bus write after the cache write
  assign pop_vld = (cur_state == WCA && wca_grant && wb_q) ||
                   (cur_state == WBUS && wbus_cmplt);

  assign entry_vld = (cur_state != IDLE);
  assign state     = cur_state;

endmodule

//--- source/stb_entry_result.sv
// ========================================
// Entry result logic. Compares the entry
// address with the cache pipeline and
// presents the formatted write request
// ========================================
`include "stb_params.svh"

module stb_entry_result
  import stb_pkg::*;
(
  input  stb_state_e            state,
  input  stb_pa_u               pa,
  input  stb_attr_t             attr,
  input  logic [3:0]            way,
  input  logic [1:0]            virt_idx,
  input  logic [`STB_DATAW-1:0] data,
  input  logic [`STB_BYTEW-1:0] bytes_vld,
  input  stb_pa_u               dc_pa,
  input  logic [`STB_BYTEW-1:0] dc_bytes_vld,
  output logic                  hit_addr,
  output logic                  hit_addr_wca,
  output logic                  hit_full,
  output logic                  hit_part,
  output logic                  hit_idx,
  output logic                  so_vld,
  output logic                  dcache_req,
  output logic                  biu_req,
  output stb_req_t              req
);

  logic entry_vld;
  logic bytes_eq;
  logic bytes_ovl;

  assign entry_vld = (state != IDLE);

  // ========================================
  // Hit checks
  // ========================================
  assign hit_addr  = entry_vld && (dc_pa.dw.dw_addr == pa.dw.dw_addr);
  assign bytes_eq  = (dc_bytes_vld == bytes_vld);
  assign bytes_ovl = |(dc_bytes_vld & bytes_vld);

  assign hit_full     = hit_addr && bytes_eq;
  assign hit_part     = hit_addr && bytes_ovl && !bytes_eq;
  assign hit_addr_wca = hit_addr && bytes_ovl;

  // Same cache set, index bits just above the line offset
  assign hit_idx = entry_vld &&
                   (dc_pa.line.line_addr[`STB_TAG_INDEX_W-1:0] ==
                    pa.line.line_addr[`STB_TAG_INDEX_W-1:0]);

  // ========================================
  // Write request
  // ========================================
  assign dcache_req = (state == WCA);
  assign biu_req    = (state == WBUS);
  assign so_vld     = entry_vld && !attr.wo;

  always_comb begin
    // Write-ordered requests are doubleword aligned
    req.pa        = {pa.dw.dw_addr, attr.wo ? 3'b000 : pa.dw.byte_off};
    req.size      = attr.size;
    req.prot      = attr.prot;
    req.cache     = attr.cache;
    req.user      = attr.user;
    req.way       = way;
    req.idx       = {virt_idx, pa[11:0]};
    req.data      = data;
    req.bytes_vld = bytes_vld;
  end

endmodule

//--- source/stb_params.svh
// ========================================
// Widths and field positions shared by the
// store buffer entry. Include this file
// wherever a width or attribute bit is used
// ========================================
`ifndef STB_PARAMS_SVH
`define STB_PARAMS_SVH

// Address and data widths
`define STB_PADDR        40
`define STB_DATAW        64
`define STB_BYTEW        8

// Offsets inside a physical address
`define STB_LINE_OFF     6
`define STB_DW_OFF       3
`define STB_TAG_INDEX_W  8

// Bit positions in the 3-bit attribute field
`define STB_ATTR_CA      0
`define STB_ATTR_SO      1
`define STB_ATTR_BUF     2

`endif

//--- source/stb_pkg.sv
// ========================================
// Types of the store buffer entry: state
// encoding, address views, create request,
// bus attributes and the write request
// ========================================
`include "stb_params.svh"

package stb_pkg;

  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    FWD   = 3'd1,
    WCA   = 3'd2,
    MERGE = 3'd3,
    WBUS  = 3'd4
  } stb_state_e;

  // Line view for line compare and cache index
  typedef struct packed {
    logic [`STB_PADDR-`STB_LINE_OFF-1:0] line_addr;
    logic [`STB_LINE_OFF-1:0]            line_off;
  } stb_pa_line_t;

  // Doubleword view for hit check and offset zeroing
  typedef struct packed {
    logic [`STB_PADDR-`STB_DW_OFF-1:0] dw_addr;
    logic [`STB_DW_OFF-1:0]            byte_off;
  } stb_pa_dw_t;

  typedef union packed {
    stb_pa_line_t line;
    stb_pa_dw_t   dw;
  } stb_pa_u;

  typedef struct packed {
    stb_pa_u                pa;
    logic [`STB_DATAW-1:0]  data;
    logic [`STB_BYTEW-1:0]  bytes_vld;
    logic [2:0]             attr;
    logic [1:0]             size;
    logic [1:0]             priv_mode;
    logic                   lock;
    logic                   alct;
    logic                   cache_hit;
    logic                   src2_depd;
    logic [4:0]             src2_reg;
    logic [2:0]             shift;
    logic [3:0]             way;
    logic [1:0]             virt_idx;
  } stb_create_t;

  // Attributes as presented on the bus
  typedef struct packed {
    logic       wo;
    logic [2:0] size;
    logic [2:0] prot;
    logic [3:0] cache;
    logic       user;
  } stb_attr_t;

  typedef struct packed {
    logic [`STB_PADDR-1:0]  pa;
    logic [2:0]             size;
    logic [2:0]             prot;
    logic [3:0]             cache;
    logic                   user;
    logic [3:0]             way;
    logic [13:0]            idx;
    logic [`STB_DATAW-1:0]  data;
    logic [`STB_BYTEW-1:0]  bytes_vld;
  } stb_req_t;

endpackage

//--- tb/stb_entry_tb.sv
// ========================================
// Testbench for one store buffer entry.
// Drives create, merge, forward and grant
// traffic and checks the DUT with assertions
// against a small reference model
// ========================================
`include "stb_params.svh"

module stb_entry_tb
  import stb_pkg::*;
();

  logic                  stb_fsm_clk;
  logic                  cpurst_b;
  logic                  create_en;
  stb_create_t           create;
  logic                  dcache_wb;
  logic                  merge_req;
  logic [`STB_DATAW-1:0] merge_data;
  logic [`STB_BYTEW-1:0] merge_bytes_vld;
  logic                  merge_finish;
  stb_pa_u               dc_pa;
  logic [`STB_BYTEW-1:0] dc_bytes_vld;
  logic                  fwd_vld;
  logic [4:0]            fwd_dest_reg;
  logic [`STB_DATAW-1:0] fwd_data;
  logic                  wca_grant;
  logic                  wbus_cmplt;
  logic                  entry_vld;
  logic                  so_vld;
  logic                  dcache_req;
  logic                  biu_req;
  logic                  merge_en;
  logic                  pop_vld;
  logic                  fwd_hit;
  logic                  hit_addr;
  logic                  hit_addr_wca;
  logic                  hit_full;
  logic                  hit_part;
  logic                  hit_idx;
  stb_req_t              req;

  // Reference model of the live store
  stb_create_t           ref_c;
  logic [`STB_DATAW-1:0] ref_data;
  logic [`STB_BYTEW-1:0] ref_bv;
  logic                  ref_wb;

  stb_entry UUT (.*);

  initial begin
    stb_fsm_clk = 1'b0;
    forever #4 stb_fsm_clk = ~stb_fsm_clk;
  end

  // ========================================
  // Checking
  // ========================================
  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [159:0] got,
                             input logic [159:0] exp);
    assert (got == exp) else begin
      $display("mismatch %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_value(name, 160'(got), 160'(exp));
  endtask

  // Idle entry raises nothing
  assert property (@(posedge stb_fsm_clk) disable iff (!cpurst_b)
    !entry_vld |-> !(dcache_req || biu_req || merge_en || so_vld || pop_vld))
    else begin
      $display("mismatch idle outputs got 0x%0h expected 0x0",
               $sampled({dcache_req, biu_req, merge_en, so_vld, pop_vld}));
      abort_run();
    end

  assert property (@(posedge stb_fsm_clk) disable iff (!cpurst_b)
    pop_vld |=> !entry_vld)
    else begin
      $display("mismatch entry_vld after pop_vld got 0x1 expected 0x0");
      abort_run();
    end

  // Forward hit is a single pulse
  assert property (@(posedge stb_fsm_clk) disable iff (!cpurst_b)
    fwd_hit |=> !fwd_hit)
    else begin
      $display("mismatch fwd_hit second cycle got 0x1 expected 0x0");
      abort_run();
    end

  function automatic stb_req_t expected_req();
    stb_req_t e;
    logic     wo;
    wo = !ref_c.attr[`STB_ATTR_SO];
    e.pa = ref_c.pa;
    if (wo) e.pa[2:0] = 3'b000;
    e.size = wo ? 3'd3 : {1'b0, ref_c.size};
    e.prot = {2'b01, ref_c.priv_mode[0]};
    e.user = ref_c.priv_mode[1];
    e.cache = {ref_c.alct, ref_c.attr[`STB_ATTR_CA], wo,
               ref_c.attr[`STB_ATTR_CA] ? ref_wb : ref_c.attr[`STB_ATTR_BUF]};
    e.way = ref_c.way;
    e.idx = {ref_c.virt_idx, ref_c.pa[11:0]};
    e.data = ref_data;
    e.bytes_vld = ref_bv;
    return e;
  endfunction

  task automatic check_req();
    check_value("req", 160'(req), 160'(expected_req()));
    check_bit("so_vld", so_vld, ref_c.attr[`STB_ATTR_SO]);
  endtask

  // ========================================
  // Stimulus
  // ========================================
  task automatic next_cycle();
    @(posedge stb_fsm_clk);
    #1;
  endtask

  // Selects 0 dcache_req, 1 biu_req, 2 merge_en, 3 entry released
  task automatic wait_for(input string name, input int sel);
    int   n;
    logic seen;
    n = 0;
    seen = 1'b0;
    while (!seen) begin
      @(negedge stb_fsm_clk);
      case (sel)
        0:       seen = dcache_req;
        1:       seen = biu_req;
        2:       seen = merge_en;
        default: seen = !entry_vld;
      endcase
      n++;
      if (!seen && n > 32) begin
        $display("timeout while waiting for %s", name);
        abort_run();
      end
    end
  endtask

  task automatic random_create(input logic hit, ca, so, lock, depd);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    r0 = $urandom;
    r1 = $urandom;
    r2 = $urandom;
    ref_c.pa        = {r2[7:0], r0};
    ref_c.data      = {r1, r0 ^ r2};
    ref_c.bytes_vld = r2[15:8];
    ref_c.attr      = {r1[8], so, ca};
    ref_c.size      = r1[10:9];
    ref_c.priv_mode = r1[12:11];
    ref_c.lock      = lock;
    ref_c.alct      = r1[13];
    ref_c.cache_hit = hit;
    ref_c.src2_depd = depd;
    ref_c.src2_reg  = r1[18:14];
    ref_c.shift     = r1[21:19];
    ref_c.way       = r1[25:22];
    ref_c.virt_idx  = r1[27:26];
    ref_data = ref_c.data;
    ref_bv   = ref_c.bytes_vld;
  endtask

  task automatic load_entry(input logic wb);
    create    = ref_c;
    dcache_wb = wb;
    ref_wb    = wb;
    create_en = 1'b1;
    next_cycle();
    create_en = 1'b0;
  endtask

  task automatic pulse_done(input logic is_wca, input logic exp_pop);
    if (is_wca) wca_grant = 1'b1;
    else wbus_cmplt = 1'b1;
    @(negedge stb_fsm_clk);
    check_bit("pop_vld", pop_vld, exp_pop);
    next_cycle();
    wca_grant  = 1'b0;
    wbus_cmplt = 1'b0;
  endtask

  // Bus write to completion, then the entry must be free
  task automatic finish_on_bus();
    wait_for("biu_req", 1);
    check_req();
    next_cycle();
    pulse_done(1'b0, 1'b1);
    wait_for("entry release", 3);
    next_cycle();
  endtask

  task automatic cache_hit_store(input logic wb);
    random_create(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
    load_entry(wb);
    wait_for("dcache_req", 0);
    check_req();
    next_cycle();
    pulse_done(1'b1, wb);
    if (wb) begin
      wait_for("entry release", 3);
      next_cycle();
    end else begin
      finish_on_bus();
    end
  endtask

  task automatic merge_once(input logic hits, input logic [7:0] mb);
    logic [31:0] r0;
    logic [31:0] r1;
    r0 = $urandom;
    r1 = $urandom;
    merge_req       = 1'b1;
    merge_data      = {r1, r0};
    merge_bytes_vld = mb;
    @(negedge stb_fsm_clk);
    check_bit("merge_en", merge_en, hits);
    if (hits) begin
      for (int i = 0; i < 8; i++) begin
        if (mb[i]) ref_data[i*8 +: 8] = merge_data[i*8 +: 8];
      end
      ref_bv = ref_bv | mb;
    end
    next_cycle();
    merge_req = 1'b0;
    @(negedge stb_fsm_clk);
    check_value("req.data", 160'(req.data), 160'(ref_data));
    check_value("req.bytes_vld", 160'(req.bytes_vld), 160'(ref_bv));
    next_cycle();
  endtask

  task automatic merge_store(input logic by_full);
    logic [31:0] r;
    r = $urandom;
    random_create(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    // Top byte stays empty so the first merge cannot fill the entry
    ref_c.bytes_vld[7] = 1'b0;
    ref_bv = ref_c.bytes_vld;
    load_entry(r[0]);
    dc_pa = ref_c.pa;
    wait_for("merge_en", 2);
    next_cycle();
    merge_once(1'b1, {1'b0, r[7:1]});
    dc_pa = ref_c.pa ^ 40'h80;
    merge_once(1'b0, r[15:8]);
    dc_pa = ref_c.pa;
    if (by_full) begin
      merge_once(1'b1, 8'hff);
    end else begin
      merge_finish = 1'b1;
      next_cycle();
      merge_finish = 1'b0;
    end
    finish_on_bus();
  endtask

  task automatic forward_store();
    logic [31:0] r0;
    logic [31:0] r1;
    int          sh;
    r0 = $urandom;
    r1 = $urandom;
    random_create(1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
    load_entry(1'b1);
    fwd_vld      = 1'b1;
    fwd_dest_reg = ref_c.src2_reg ^ 5'd1;
    fwd_data     = {r0, r1};
    @(negedge stb_fsm_clk);
    check_bit("fwd_hit", fwd_hit, 1'b0);
    next_cycle();
    fwd_dest_reg = ref_c.src2_reg;
    fwd_data     = {r1, r0};
    @(negedge stb_fsm_clk);
    check_bit("fwd_hit", fwd_hit, 1'b1);
    // Byte i of the result is byte i+shift of the bus, wrapping
    sh = int'(ref_c.shift);
    for (int i = 0; i < 8; i++) begin
      ref_data[i*8 +: 8] = fwd_data[((i + sh) % 8)*8 +: 8];
    end
    next_cycle();
    // Matching forward stays on the bus after the entry has left FWD
    next_cycle();
    fwd_vld = 1'b0;
    wait_for("dcache_req", 0);
    check_req();
    next_cycle();
    pulse_done(1'b1, 1'b1);
    wait_for("entry release", 3);
    next_cycle();
  endtask

  task automatic hit_sweep(input int count, input logic live);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [39:0] entry_pa;
    logic [39:0] probe;
    logic [7:0]  probe_bv;
    logic        e_addr;
    logic        e_eq;
    logic        e_ovl;
    entry_pa = ref_c.pa;
    repeat (count) begin
      r0 = $urandom;
      r1 = $urandom;
      probe = {r1[7:0], r0};
      case (r1[9:8])
        2'd0:    probe[39:3] = entry_pa[39:3];
        2'd1:    probe[13:6] = entry_pa[13:6];
        default: ;
      endcase
      case (r1[11:10])
        2'd0:    probe_bv = ref_bv;
        2'd1:    probe_bv = ~ref_bv;
        default: probe_bv = r1[19:12];
      endcase
      dc_pa        = probe;
      dc_bytes_vld = probe_bv;
      e_addr = live && (probe[39:3] == entry_pa[39:3]);
      e_eq   = (probe_bv == ref_bv);
      e_ovl  = |(probe_bv & ref_bv);
      @(negedge stb_fsm_clk);
      check_bit("hit_addr", hit_addr, e_addr);
      check_bit("hit_full", hit_full, e_addr && e_eq);
      check_bit("hit_part", hit_part, e_addr && e_ovl && !e_eq);
      check_bit("hit_addr_wca", hit_addr_wca, e_addr && e_ovl);
      check_bit("hit_idx", hit_idx, live && (probe[13:6] == entry_pa[13:6]));
      next_cycle();
    end
  endtask

  // ========================================
  // Test sequence
  // ========================================
  initial begin
    void'($urandom(32'h9fb4));
    cpurst_b        = 1'b0;
    create_en       = 1'b0;
    create          = '0;
    dcache_wb       = 1'b0;
    merge_req       = 1'b0;
    merge_data      = '0;
    merge_bytes_vld = '0;
    merge_finish    = 1'b0;
    dc_pa           = '0;
    dc_bytes_vld    = '0;
    fwd_vld         = 1'b0;
    fwd_dest_reg    = '0;
    fwd_data        = '0;
    wca_grant       = 1'b0;
    wbus_cmplt      = 1'b0;
    ref_c           = '0;
    ref_wb          = 1'b0;
    repeat (16) @(posedge stb_fsm_clk);
    #1;
    cpurst_b = 1'b1;
    @(negedge stb_fsm_clk);
    check_bit("entry_vld", entry_vld, 1'b0);
    check_bit("pop_vld", pop_vld, 1'b0);
    next_cycle();

    cache_hit_store(1'b1);
    cache_hit_store(1'b0);

    // Strongly ordered, then locked
    random_create(1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
    load_entry(1'b0);
    finish_on_bus();
    random_create(1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
    load_entry(1'b1);
    finish_on_bus();

    merge_store(1'b1);
    merge_store(1'b0);
    forward_store();

    random_create(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    load_entry(1'b0);
    wait_for("biu_req", 1);
    next_cycle();
    hit_sweep(40, 1'b1);
    pulse_done(1'b0, 1'b1);
    hit_sweep(8, 1'b0);

    $display("Done: no errors");
    $finish;
  end

endmodule
